// File: design/smem_settings.svh
`ifndef SMEM_SETTINGS_SVH
`define SMEM_SETTINGS_SVH

// ********************
// sizes
// ********************

`define SMEM_NUM_REQS       4   // request lanes
`define SMEM_NUM_BANKS      4   // power of two
`define SMEM_BANK_DEPTH     16  // rows per bank
`define SMEM_WORD_BYTES     4
`define SMEM_TAG_WIDTH      4
`define SMEM_PERF_CTR_BITS  16

// ********************
// derived widths
// ********************

`define SMEM_WORD_WIDTH     (8 * `SMEM_WORD_BYTES)
`define SMEM_BANK_BITS      ($clog2(`SMEM_NUM_BANKS))
`define SMEM_ROW_BITS       ($clog2(`SMEM_BANK_DEPTH))
`define SMEM_ADDR_BITS      (`SMEM_BANK_BITS + `SMEM_ROW_BITS)
`define SMEM_LANE_BITS      ($clog2(`SMEM_NUM_REQS))
`define SMEM_CNT_BITS       ($clog2(`SMEM_NUM_REQS + 1))  // popcount of lanes

`endif

// File: design/smem_pkg.sv
`include "smem_settings.svh"

package smem_pkg;

    // word address, raw or split into row / bank id
    typedef union packed {
        logic [`SMEM_ADDR_BITS-1:0] word;
        struct packed {
            logic [`SMEM_ROW_BITS-1:0]  row;  // high part
            logic [`SMEM_BANK_BITS-1:0] bid;  // low bits pick the bank
        } split;
    } smem_addr_u;

    // ********************
    // lane side
    // ********************

    typedef struct packed {
        logic                          rw;  // 1 = write
        smem_addr_u                    addr;
        logic [`SMEM_WORD_BYTES-1:0]   byteen;
        logic [`SMEM_WORD_WIDTH-1:0]   data;
        logic [`SMEM_TAG_WIDTH-1:0]    tag;
    } core_req_t;

    typedef struct packed {
        logic                          rw;
        logic [`SMEM_WORD_WIDTH-1:0]   data;  // zero for writes
        logic [`SMEM_TAG_WIDTH-1:0]    tag;
    } core_rsp_t;

    // ********************
    // bank side
    // ********************

    typedef struct packed {
        logic                          rw;
        logic [`SMEM_ROW_BITS-1:0]     row;
        logic [`SMEM_WORD_BYTES-1:0]   byteen;
        logic [`SMEM_WORD_WIDTH-1:0]   data;
        logic [`SMEM_LANE_BITS-1:0]    tid;  // lane that owns the request
        logic [`SMEM_TAG_WIDTH-1:0]    tag;
    } bank_req_t;

    typedef struct packed {
        logic                          rw;
        logic [`SMEM_WORD_WIDTH-1:0]   data;
        logic [`SMEM_LANE_BITS-1:0]    tid;
        logic [`SMEM_TAG_WIDTH-1:0]    tag;
    } bank_rsp_t;

endpackage

// File: design/smem_init_ctrl.sv
`timescale 1ns/100ps
`include "smem_settings.svh"

module smem_init_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    output logic                        req_enable,
    output logic                        clr_en,
    output logic [`SMEM_ROW_BITS-1:0]   clr_row
);

    localparam int ROW_BITS = `SMEM_ROW_BITS;
    localparam logic [ROW_BITS-1:0] LAST_ROW = ROW_BITS'(`SMEM_BANK_DEPTH - 1);

    localparam logic ST_CLEAR = 1'b0;
    localparam logic ST_RUN   = 1'b1;

    logic                state;
    logic [ROW_BITS-1:0] row_cnt;

    // ********************
    // clear sequencer
    // ********************

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_CLEAR;
            row_cnt <= '0;
        end else begin
            case (state)
                ST_CLEAR: begin
                    row_cnt <= row_cnt + 1'b1;
                    if (row_cnt == LAST_ROW) begin
                        state <= ST_RUN;  // all rows zeroed
                    end
                end
                default: begin
                    state <= ST_RUN;
                end
            endcase
        end
    end

    // one row of every bank per cycle
    assign clr_en     = (state == ST_CLEAR);
    assign clr_row    = row_cnt;
    assign req_enable = (state == ST_RUN);

endmodule

// File: design/bank_stall_counter.sv
`timescale 1ns/100ps
`include "smem_settings.svh"

module bank_stall_counter (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             req_enable,
    input  logic [`SMEM_NUM_REQS-1:0]        lane_valid,
    input  logic [`SMEM_NUM_REQS-1:0]        lane_ready,
    output logic [`SMEM_PERF_CTR_BITS-1:0]   bank_stalls
);

    localparam int NUM_REQS = `SMEM_NUM_REQS;
    localparam int CNT_BITS = `SMEM_CNT_BITS;
    localparam int CTR_BITS = `SMEM_PERF_CTR_BITS;

    logic [CNT_BITS-1:0] stall_cnt;
    logic [CTR_BITS:0]   stall_sum;  // one spare bit for overflow

    // lanes waiting this cycle
    always_comb begin
        stall_cnt = '0;
        for (int i = 0; i < NUM_REQS; i++) begin
            stall_cnt = stall_cnt + CNT_BITS'(lane_valid[i] & ~lane_ready[i]);
        end
    end

    assign stall_sum = {1'b0, bank_stalls} + (CTR_BITS + 1)'(stall_cnt);

    always_ff @(posedge clk) begin
        if (reset) begin
            bank_stalls <= '0;
        end else if (req_enable) begin
            bank_stalls <= stall_sum[CTR_BITS] ? '1 : stall_sum[CTR_BITS-1:0];  // saturate
        end
    end

endmodule

// File: design/bank_req_sel.sv
`timescale 1ns/100ps
`include "smem_settings.svh"

module bank_req_sel (
    input  logic [`SMEM_NUM_REQS-1:0]                        core_req_valid,
    input  smem_pkg::core_req_t [`SMEM_NUM_REQS-1:0]         core_req,
    output logic [`SMEM_NUM_REQS-1:0]                        core_req_ready,
    input  logic                                             req_enable,
    output logic [`SMEM_NUM_BANKS-1:0]                       bank_req_valid,
    output smem_pkg::bank_req_t [`SMEM_NUM_BANKS-1:0]        bank_req,
    input  logic [`SMEM_NUM_BANKS-1:0]                       bank_req_ready
);

    localparam int NUM_REQS  = `SMEM_NUM_REQS;
    localparam int BANK_BITS = `SMEM_BANK_BITS;
    localparam int ROW_BITS  = `SMEM_ROW_BITS;
    localparam int LANE_BITS = `SMEM_LANE_BITS;

    smem_pkg::smem_addr_u [NUM_REQS-1:0]  lane_addr;
    logic [NUM_REQS-1:0][BANK_BITS-1:0]   lane_bid;
    logic [NUM_REQS-1:0][ROW_BITS-1:0]    lane_row;

    // ********************
    // address decode
    // ********************

    always_comb begin
        for (int i = 0; i < NUM_REQS; i++) begin
            lane_addr[i] = '0;
            lane_addr[i].word = core_req[i].addr.word;  // load raw word
            lane_bid[i] = lane_addr[i].split.bid;        // read back split
            lane_row[i] = lane_addr[i].split.row;
        end
    end

    // ********************
    // one lane per bank
    // ********************

    // walk from the top so the lowest valid lane is written last and wins
    always_comb begin
        bank_req_valid = '0;
        bank_req       = '0;
        for (int i = NUM_REQS - 1; i >= 0; i--) begin
            if (core_req_valid[i] && req_enable) begin
                bank_req_valid[lane_bid[i]]      = 1'b1;
                bank_req[lane_bid[i]].rw         = core_req[i].rw;
                bank_req[lane_bid[i]].row        = lane_row[i];
                bank_req[lane_bid[i]].byteen     = core_req[i].byteen;
                bank_req[lane_bid[i]].data       = core_req[i].data;
                bank_req[lane_bid[i]].tid        = LANE_BITS'(i);
                bank_req[lane_bid[i]].tag        = core_req[i].tag;
            end
        end
    end

    // a lane moves only if it owns its bank and the bank can take it
    always_comb begin
        for (int i = 0; i < NUM_REQS; i++) begin
            core_req_ready[i] = bank_req_valid[lane_bid[i]]
                             && (bank_req[lane_bid[i]].tid == LANE_BITS'(i))
                             && core_req_valid[i]
                             && bank_req_ready[lane_bid[i]];
        end
    end

endmodule

// File: design/smem_bank.sv
`timescale 1ns/100ps
`include "smem_settings.svh"

module smem_bank (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req_valid,
    input  smem_pkg::bank_req_t         req,
    output logic                        req_ready,
    output logic                        rsp_valid,
    output smem_pkg::bank_rsp_t         rsp,
    input  logic                        rsp_ready,
    input  logic                        clr_en,
    input  logic [`SMEM_ROW_BITS-1:0]   clr_row
);

    localparam int DEPTH      = `SMEM_BANK_DEPTH;
    localparam int WORD_WIDTH = `SMEM_WORD_WIDTH;
    localparam int WORD_BYTES = `SMEM_WORD_BYTES;

    logic [WORD_WIDTH-1:0] mem [DEPTH];
    logic                  req_fire;

    // free slot, or the held response leaves this cycle
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;

    // ********************
    // storage
    // ********************

    always_ff @(posedge clk) begin
        if (clr_en) begin
            mem[clr_row] <= '0;
        end else if (req_fire && req.rw) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (req.byteen[b]) begin
                    mem[req.row][b*8 +: 8] <= req.data[b*8 +: 8];
                end
            end
        end
    end

    // ********************
    // response register
    // ********************

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (req_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp.rw   <= req.rw;
            rsp.data <= req.rw ? '0 : mem[req.row];  // old row content on read
            rsp.tid  <= req.tid;
            rsp.tag  <= req.tag;
        end
    end

endmodule

// File: design/bank_rsp_merge.sv
`timescale 1ns/100ps
`include "smem_settings.svh"

module bank_rsp_merge (
    input  logic [`SMEM_NUM_BANKS-1:0]                   bank_rsp_valid,
    input  smem_pkg::bank_rsp_t [`SMEM_NUM_BANKS-1:0]    bank_rsp,
    output logic [`SMEM_NUM_BANKS-1:0]                   bank_rsp_ready,
    output logic [`SMEM_NUM_REQS-1:0]                    core_rsp_valid,
    output smem_pkg::core_rsp_t [`SMEM_NUM_REQS-1:0]     core_rsp,
    input  logic [`SMEM_NUM_REQS-1:0]                    core_rsp_ready
);

    localparam int NUM_REQS  = `SMEM_NUM_REQS;
    localparam int NUM_BANKS = `SMEM_NUM_BANKS;
    localparam int BANK_BITS = `SMEM_BANK_BITS;

    logic [NUM_REQS-1:0][BANK_BITS-1:0] lane_bank;  // bank chosen per lane

    // highest bank first, lower banks overwrite
    always_comb begin
        core_rsp_valid = '0;
        core_rsp       = '0;
        lane_bank      = '0;
        for (int b = NUM_BANKS - 1; b >= 0; b--) begin
            if (bank_rsp_valid[b]) begin
                core_rsp_valid[bank_rsp[b].tid] = 1'b1;
                core_rsp[bank_rsp[b].tid].rw    = bank_rsp[b].rw;
                core_rsp[bank_rsp[b].tid].data  = bank_rsp[b].data;
                core_rsp[bank_rsp[b].tid].tag   = bank_rsp[b].tag;
                lane_bank[bank_rsp[b].tid]      = BANK_BITS'(b);
            end
        end
    end

    // losers keep their response for a later cycle
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_rsp_ready[b] = bank_rsp_valid[b]
                             && (lane_bank[bank_rsp[b].tid] == BANK_BITS'(b))
                             && core_rsp_ready[bank_rsp[b].tid];
        end
    end

endmodule

// File: design/smem_top.sv
`timescale 1ns/100ps
`include "smem_settings.svh"

module smem_top (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic [`SMEM_NUM_REQS-1:0]                    core_req_valid,
    input  smem_pkg::core_req_t [`SMEM_NUM_REQS-1:0]     core_req,
    output logic [`SMEM_NUM_REQS-1:0]                    core_req_ready,
    output logic [`SMEM_NUM_REQS-1:0]                    core_rsp_valid,
    output smem_pkg::core_rsp_t [`SMEM_NUM_REQS-1:0]     core_rsp,
    input  logic [`SMEM_NUM_REQS-1:0]                    core_rsp_ready,
    output logic [`SMEM_PERF_CTR_BITS-1:0]               bank_stalls,
    output logic                                         init_busy
);

    localparam int NUM_BANKS = `SMEM_NUM_BANKS;

    logic                                   req_enable;
    logic                                   clr_en;
    logic [`SMEM_ROW_BITS-1:0]              clr_row;

    logic [NUM_BANKS-1:0]                   bank_req_valid;
    smem_pkg::bank_req_t [NUM_BANKS-1:0]    bank_req;
    logic [NUM_BANKS-1:0]                   bank_req_ready;
    logic [NUM_BANKS-1:0]                   bank_rsp_valid;
    smem_pkg::bank_rsp_t [NUM_BANKS-1:0]    bank_rsp;
    logic [NUM_BANKS-1:0]                   bank_rsp_ready;

    assign init_busy = !req_enable;

    smem_init_ctrl smem_init_ctrl_inst (
        .clk        (clk),
        .reset      (reset),
        .req_enable (req_enable),
        .clr_en     (clr_en),
        .clr_row    (clr_row)
    );

    bank_stall_counter bank_stall_counter_inst (
        .clk         (clk),
        .reset       (reset),
        .req_enable  (req_enable),
        .lane_valid  (core_req_valid),
        .lane_ready  (core_req_ready),
        .bank_stalls (bank_stalls)
    );

    bank_req_sel bank_req_sel_inst (
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .req_enable     (req_enable),
        .bank_req_valid (bank_req_valid),
        .bank_req       (bank_req),
        .bank_req_ready (bank_req_ready)
    );

    // ********************
    // banks
    // ********************

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        smem_bank smem_bank_inst (
            .clk       (clk),
            .reset     (reset),
            .req_valid (bank_req_valid[b]),
            .req       (bank_req[b]),
            .req_ready (bank_req_ready[b]),
            .rsp_valid (bank_rsp_valid[b]),
            .rsp       (bank_rsp[b]),
            .rsp_ready (bank_rsp_ready[b]),
            .clr_en    (clr_en),
            .clr_row   (clr_row)
        );
    end

    bank_rsp_merge bank_rsp_merge_inst (
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp       (bank_rsp),
        .bank_rsp_ready (bank_rsp_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready)
    );

endmodule

// File: tests/smem_tb.sv
`timescale 1ns/100ps
`include "smem_settings.svh"

module smem_tb;

    localparam int NR        = `SMEM_NUM_REQS;
    localparam int NB        = `SMEM_NUM_BANKS;
    localparam int TW        = `SMEM_TAG_WIDTH;
    localparam int WW        = `SMEM_WORD_WIDTH;
    localparam int AW        = `SMEM_ADDR_BITS;
    localparam int BY        = `SMEM_WORD_BYTES;
    localparam int CTR       = `SMEM_PERF_CTR_BITS;
    localparam int DEPTH     = `SMEM_BANK_DEPTH;
    localparam int LANE_TXNS = 100;
    localparam int NUM_TXNS  = NR * LANE_TXNS;
    localparam int LIMIT     = 20 * NUM_TXNS + DEPTH + 100;

    logic                         clk = 1'b0;
    logic                         reset;
    logic [NR-1:0]                core_req_valid;
    smem_pkg::core_req_t [NR-1:0] core_req;
    logic [NR-1:0]                core_req_ready;
    logic [NR-1:0]                core_rsp_valid;
    smem_pkg::core_rsp_t [NR-1:0] core_rsp;
    logic [NR-1:0]                core_rsp_ready;
    logic [CTR-1:0]               bank_stalls;
    logic                         init_busy;

    // word model and responses in flight by lane and tag
    logic [WW-1:0] model     [1 << AW] = '{default: '0};
    logic          exp_valid [NR][1 << TW] = '{default: '0};
    logic          exp_rw    [NR][1 << TW];
    logic [WW-1:0] exp_data  [NR][1 << TW];
    logic          bank_busy [NB] = '{default: '0};  // response register full
    int            bank_lane [NB];
    int            bank_tag  [NB];
    logic [NR-1:0] req_fire = '0;
    int            issued [NR] = '{default: 0};
    int            cycles = 0;
    int            rsp_count = 0;
    int            stall_total = 0;
    int            leftover = 0;

    smem_top smem_top_inst (
        .clk            (clk),
        .reset          (reset),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .bank_stalls    (bank_stalls),
        .init_busy      (init_busy)
    );

    always #2 clk = ~clk;

    task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
        $display("FAIL t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(string msg);
        $display("FAIL t=%0t %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic accept_req(int i);
        smem_pkg::core_req_t r;
        int                  a;
        r = core_req[i];
        a = int'(r.addr.word);
        exp_valid[i][r.tag] = 1'b1;
        exp_rw[i][r.tag]    = r.rw;
        exp_data[i][r.tag]  = r.rw ? '0 : model[a];  // word value at acceptance
        for (int k = 0; k < BY; k++) begin
            if (r.rw && r.byteen[k]) begin
                model[a][k*8 +: 8] = r.data[k*8 +: 8];
            end
        end
        bank_busy[a % NB] = 1'b1;  // low address bits pick the bank
        bank_lane[a % NB] = i;
        bank_tag[a % NB]  = int'(r.tag);
    endtask

    task automatic check_cycle();
        int   disp [NR];
        logic freed [NB];
        logic init_pred;
        logic pred;
        logic lower;
        int   b;
        int   t;
        init_pred = cycles < DEPTH;
        assert (init_busy === init_pred)
            else report_mismatch("init_busy", 64'(init_pred), 64'(init_busy));
        assert (bank_stalls === CTR'(stall_total))
            else report_mismatch("bank_stalls", 64'(stall_total), 64'(bank_stalls));

        // ********************
        // responses
        // ********************
        for (int l = 0; l < NR; l++) begin
            disp[l] = -1;
            for (int k = NB - 1; k >= 0; k--) begin
                if (bank_busy[k] && bank_lane[k] == l) begin
                    disp[l] = k;  // lowest bank shows first
                end
            end
            assert (core_rsp_valid[l] === (disp[l] >= 0))
                else report_mismatch($sformatf("core_rsp_valid[%0d]", l),
                                     64'(disp[l] >= 0), 64'(core_rsp_valid[l]));
            if (disp[l] >= 0) begin
                t = bank_tag[disp[l]];
                assert (exp_valid[l][core_rsp[l].tag])
                    else report_error($sformatf("response on lane %0d carries a tag not in flight",
                                                l));
                assert (core_rsp[l].tag === TW'(t))
                    else report_mismatch($sformatf("core_rsp[%0d].tag", l), 64'(t),
                                         64'(core_rsp[l].tag));
                assert (core_rsp[l].rw === exp_rw[l][t])
                    else report_mismatch($sformatf("core_rsp[%0d].rw", l), 64'(exp_rw[l][t]),
                                         64'(core_rsp[l].rw));
                assert (core_rsp[l].data === exp_data[l][t])
                    else report_mismatch($sformatf("core_rsp[%0d].data", l),
                                         64'(exp_data[l][t]), 64'(core_rsp[l].data));
            end
        end
        for (int k = 0; k < NB; k++) begin
            freed[k] = bank_busy[k] && disp[bank_lane[k]] == k
                    && core_rsp_ready[bank_lane[k]];
        end

        // ********************
        // requests
        // ********************
        for (int i = 0; i < NR; i++) begin
            b = int'(core_req[i].addr.word) % NB;
            lower = 1'b0;
            for (int j = 0; j < i; j++) begin
                if (core_req_valid[j] && int'(core_req[j].addr.word) % NB == b) begin
                    lower = 1'b1;  // a lower lane owns the bank
                end
            end
            pred = core_req_valid[i] && !lower && !init_pred && (!bank_busy[b] || freed[b]);
            assert (core_req_ready[i] === pred)
                else report_mismatch($sformatf("core_req_ready[%0d]", i), 64'(pred),
                                     64'(core_req_ready[i]));
            if (core_req_valid[i] && !pred && !init_pred) begin
                stall_total++;
            end
        end

        // state after the coming edge
        for (int k = 0; k < NB; k++) begin
            if (freed[k]) begin
                exp_valid[bank_lane[k]][bank_tag[k]] = 1'b0;
                bank_busy[k] = 1'b0;
                rsp_count++;
            end
        end
        for (int i = 0; i < NR; i++) begin
            req_fire[i] = core_req_valid[i] && core_req_ready[i];
            if (req_fire[i]) begin
                accept_req(i);
            end
        end
    endtask

    task automatic drive_inputs();
        smem_pkg::core_req_t r;
        for (int i = 0; i < NR; i++) begin
            core_rsp_ready[i] <= ($urandom % 4) != 0;  // random back-pressure
            if (!core_req_valid[i] || req_fire[i]) begin
                if (issued[i] < LANE_TXNS && ($urandom % 4) != 0) begin
                    r.rw        = 1'($urandom % 2);
                    r.addr.word = AW'($urandom % 32);  // small range for frequent conflicts
                    r.byteen    = BY'($urandom);
                    r.data      = WW'($urandom);
                    r.tag       = TW'(issued[i]);  // per-lane sequence mod 16
                    issued[i]++;
                    core_req[i]       <= r;
                    core_req_valid[i] <= 1'b1;
                end else begin
                    core_req_valid[i] <= 1'b0;
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'hebf711e4));
        reset          <= 1'b1;
        core_req_valid <= '0;
        core_req       <= '0;
        core_rsp_ready <= '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        while (rsp_count < NUM_TXNS) begin
            @(negedge clk);
            assert (cycles < LIMIT) else report_error("timeout, requests still without response");
            check_cycle();
            cycles++;
            @(posedge clk);
            drive_inputs();
        end
        @(negedge clk);
        assert (bank_stalls === CTR'(stall_total))
            else report_mismatch("bank_stalls", 64'(stall_total), 64'(bank_stalls));
        for (int l = 0; l < NR; l++) begin
            leftover += int'(core_rsp_valid[l]);
        end
        if (leftover == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_error($sformatf("%0d lanes still show a response after the last one was taken",
                                   leftover));
        end
    end

endmodule

// File: tb.f
+incdir+design
design/smem_pkg.sv
design/smem_init_ctrl.sv
design/bank_stall_counter.sv
design/bank_req_sel.sv
design/smem_bank.sv
design/bank_rsp_merge.sv
design/smem_top.sv
tests/smem_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module smem_tb
./obj_dir/Vsmem_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1
